/* common/txPkg.sv */
package txPkg;

	localparam int numChannels = 8;
	localparam int bufferDepth = 2;

	typedef logic [14:0] progAddr_t;
	typedef logic [15:0] instrType_t;
	typedef logic [15:0] instrData_t;
	typedef logic [31:0] delay_t;
	typedef logic [numChannels-1:0] chanBits_t;
	typedef logic [15:0] pulseTime_t;

	// occupancy of the instruction buffer from 0 up to bufferDepth
	typedef logic [$clog2(bufferDepth+1)-1:0] bufCount_t;

	// instrData carries trigger values in 7:0 and LED values in 15:8
	typedef struct packed {
		instrType_t instrType;
		instrData_t instrData;
		delay_t delay;
	} instrWord_t;

	typedef struct packed {
		pulseTime_t startTime;
		pulseTime_t onTime;
	} channelTiming_t;

	typedef channelTiming_t [numChannels-1:0] channelTimingArray_t;

	// control command codes as seen on the command register
	typedef enum logic [7:0] {
		cmdHardReset = 8'd0,
		cmdSoftReset = 8'd1,
		cmdLoadProgram = 8'd2,
		cmdSetTrig = 8'd4,
		cmdSetTrigRest = 8'd5,
		cmdTestTrig = 8'd6,
		cmdSetLed = 8'd8,
		cmdRunProgram = 8'd128
	} txCommand_t;

	// bit positions in the one-hot instruction type
	localparam int bitSetTrig = 0;
	localparam int bitSetLeds = 1;
	localparam int bitTriggerRecv = 2;
	localparam int bitWaitExtTrig = 4;
	localparam int bitFirePulse = 5;
	localparam int bitProgramEnd = 15;

endpackage

/* hdl/instructionFetcher.sv */
module instructionFetcher (
	input  logic txCLK,
	input  logic rst,
	input  logic fetchRestart,
	input  logic fetchEnable,
	input  txPkg::progAddr_t startAddr,
	input  txPkg::instrWord_t progWord,
	output txPkg::progAddr_t progAddr,
	input  txPkg::bufCount_t count,
	output logic push,
	output txPkg::instrWord_t pushWord
);

	txPkg::progAddr_t addrReg;
	logic inFlight;
	logic endSeen;
	logic endArriving;
	logic issue;
	txPkg::bufCount_t pending;

	// words already queued plus the one coming back from memory
	assign pending = count + txPkg::bufCount_t'(inFlight);

	// stop issuing as soon as the end word is on its way into the buffer
	assign endArriving = inFlight && progWord.instrType[txPkg::bitProgramEnd];

	assign issue = fetchEnable
		&& !fetchRestart
		&& !endSeen
		&& !endArriving
		&& (pending < txPkg::bufCount_t'(txPkg::bufferDepth));

	// memory registers the address on the issue edge
	assign progAddr = addrReg;

	// the read issued last edge is back now
	assign push = inFlight;
	assign pushWord = progWord;

	always_ff @(posedge txCLK)
	begin
		if (rst)
		begin
			inFlight <= 1'b0;
			// idle until the first restart supplies an address
			endSeen <= 1'b1;
		end
		else if (fetchRestart)
		begin
			inFlight <= 1'b0;
			endSeen <= 1'b0;
		end
		else
		begin
			inFlight <= issue;
			if (endArriving)
				endSeen <= 1'b1;
		end
	end

	always_ff @(posedge txCLK)
	begin
		if (fetchRestart)
			addrReg <= startAddr;
		else if (issue)
			addrReg <= addrReg + 1'b1;
	end

endmodule

/* hdl/instructionBuffer.sv */
module instructionBuffer (
	input  logic txCLK,
	input  logic rst,
	input  logic flush,
	input  logic push,
	input  txPkg::instrWord_t pushWord,
	input  logic pop,
	output txPkg::instrWord_t headWord,
	output logic headValid,
	output txPkg::bufCount_t count
);

	txPkg::instrWord_t mem [txPkg::bufferDepth];
	logic [$clog2(txPkg::bufferDepth)-1:0] rdPtr;
	logic [$clog2(txPkg::bufferDepth)-1:0] wrPtr;
	logic doPush;
	logic doPop;

	assign headValid = (count != '0);
	assign headWord = mem[rdPtr];

	assign doPop = pop && headValid;
	assign doPush = push && (count != txPkg::bufCount_t'(txPkg::bufferDepth));

	always_ff @(posedge txCLK)
	begin
		if (doPush)
			mem[wrPtr] <= pushWord;
	end

	always_ff @(posedge txCLK)
	begin
		if (rst || flush)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			// push and pop together leave the count alone
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* sequencer/programSequencer.sv */
module programSequencer (
	input  logic txCLK,
	input  logic rst,
	input  txPkg::txCommand_t txCommand,
	input  logic extTrigger,
	input  txPkg::chanBits_t ledReg,
	input  txPkg::chanBits_t trigReg,
	input  txPkg::chanBits_t trigRestReg,
	input  txPkg::instrWord_t headWord,
	input  logic headValid,
	output logic pop,
	output logic fetchRestart,
	output logic fetchEnable,
	output txPkg::chanBits_t trigOut,
	output txPkg::chanBits_t ledOut,
	output logic adcTrigger,
	input  logic adcTriggerAck,
	output logic fireStrobe,
	output logic clearPulse
);

	txPkg::txCommand_t prevCmd;
	txPkg::chanBits_t restLevel;
	txPkg::delay_t delayCnt;
	txPkg::delay_t remaining;
	txPkg::instrType_t headType;
	logic delayLoaded;
	logic running;
	logic isEnd;
	logic trigOk;
	logic execute;

	assign running = (txCommand == txPkg::cmdRunProgram);
	assign fetchEnable = running || (txCommand == txPkg::cmdLoadProgram);
	assign clearPulse = !running;

	// restart only on the transition into load or a reset
	assign fetchRestart = (txCommand != prevCmd)
		&& (txCommand inside {txPkg::cmdHardReset, txPkg::cmdSoftReset,
			txPkg::cmdLoadProgram});

	assign headType = headWord.instrType;
	assign isEnd = headType[txPkg::bitProgramEnd];

	// a fresh head starts from its own delay field
	assign remaining = delayLoaded ? delayCnt : headWord.delay;
	assign trigOk = !headType[txPkg::bitWaitExtTrig] || extTrigger;

	assign execute = running && headValid && !isEnd && (remaining == '0) && trigOk;
	assign pop = execute;
	assign fireStrobe = execute && headType[txPkg::bitFirePulse];

	always_ff @(posedge txCLK)
	begin
		if (rst)
			prevCmd <= txPkg::cmdHardReset;
		else
			prevCmd <= txCommand;
	end

	always_ff @(posedge txCLK)
	begin
		if (rst || fetchRestart || execute)
			delayLoaded <= 1'b0;
		else if (running && headValid && !isEnd && (remaining != '0))
		begin
			delayCnt <= remaining - 1'b1;
			delayLoaded <= 1'b1;
		end
	end

	always_ff @(posedge txCLK)
	begin
		if (rst)
		begin
			trigOut <= '0;
			ledOut <= '0;
			restLevel <= '0;
		end
		else
		begin
			case (txCommand)
				txPkg::cmdHardReset:
				begin
					trigOut <= '0;
					ledOut <= '0;
					restLevel <= '0;
				end
				txPkg::cmdSetTrig:
				begin
					trigOut <= trigReg;
					ledOut <= '0;
				end
				txPkg::cmdSetTrigRest:
				begin
					restLevel <= trigRestReg;
					ledOut <= '0;
				end
				txPkg::cmdTestTrig:
				begin
					trigOut <= trigReg ^ restLevel;
					ledOut <= '0;
				end
				txPkg::cmdSetLed:
					ledOut <= ledReg;
				txPkg::cmdRunProgram:
				begin
					if (execute && headType[txPkg::bitSetTrig])
						trigOut <= headWord.instrData[7:0] ^ restLevel;
					if (execute && headType[txPkg::bitSetLeds])
						ledOut <= headWord.instrData[15:8];
				end
				// soft reset, load and unknown codes park at the rest level
				default:
				begin
					trigOut <= restLevel;
					ledOut <= '0;
				end
			endcase
		end
	end

	// held until the receive side acknowledges
	always_ff @(posedge txCLK)
	begin
		if (rst)
			adcTrigger <= 1'b0;
		else if (execute && headType[txPkg::bitTriggerRecv])
			adcTrigger <= 1'b1;
		else if (adcTriggerAck)
			adcTrigger <= 1'b0;
	end

endmodule

/* sequencer/pulseGenerator.sv */
module pulseGenerator (
	input  logic txCLK,
	input  logic rst,
	input  logic fireStrobe,
	input  logic clearPulse,
	input  txPkg::channelTimingArray_t pulseTiming,
	input  txPkg::chanBits_t channelMask,
	output txPkg::chanBits_t transducerOut,
	output logic pulseBusy
);

	txPkg::channelTimingArray_t timing;
	txPkg::pulseTime_t counter;
	txPkg::pulseTime_t chanEnd [txPkg::numChannels];
	txPkg::pulseTime_t lastEnd;
	txPkg::chanBits_t inWindow;

	always_comb
	begin
		lastEnd = '0;
		for (int c = 0; c < txPkg::numChannels; c++)
		begin
			chanEnd[c] = timing[c].startTime + timing[c].onTime;
			inWindow[c] = (counter >= timing[c].startTime) && (counter < chanEnd[c]);
			if (chanEnd[c] > lastEnd)
				lastEnd = chanEnd[c];
		end
	end

	always_ff @(posedge txCLK)
	begin
		if (fireStrobe && !pulseBusy)
			timing <= pulseTiming;
	end

	always_ff @(posedge txCLK)
	begin
		if (rst || clearPulse)
		begin
			counter <= '0;
			pulseBusy <= 1'b0;
			transducerOut <= '0;
		end
		else if (pulseBusy)
		begin
			counter <= counter + 1'b1;
			transducerOut <= inWindow & channelMask;
			// last channel window has closed
			if (counter == lastEnd)
				pulseBusy <= 1'b0;
		end
		else
		begin
			transducerOut <= '0;
			if (fireStrobe)
			begin
				counter <= '0;
				pulseBusy <= 1'b1;
			end
		end
	end

endmodule

/* hdl/txControlTop.sv */
module txControlTop (
	input  logic txCLK,
	input  logic rst,
	input  txPkg::txCommand_t txCommand,
	input  logic extTrigger,
	input  txPkg::progAddr_t startAddr,
	input  txPkg::instrWord_t progWord,
	output txPkg::progAddr_t progAddr,
	input  txPkg::channelTimingArray_t pulseTiming,
	input  txPkg::chanBits_t channelMask,
	output txPkg::chanBits_t transducerOut,
	output txPkg::chanBits_t trigOut,
	output txPkg::chanBits_t ledOut,
	output logic adcTrigger,
	input  logic adcTriggerAck,
	input  txPkg::chanBits_t ledReg,
	input  txPkg::chanBits_t trigReg,
	input  txPkg::chanBits_t trigRestReg
);

	logic fetchRestart;
	logic fetchEnable;
	logic push;
	txPkg::instrWord_t pushWord;
	logic pop;
	txPkg::instrWord_t headWord;
	logic headValid;
	txPkg::bufCount_t count;
	logic fireStrobe;
	logic clearPulse;
	logic pulseBusy;

	instructionFetcher i_fetcher (
		.txCLK(txCLK),
		.rst(rst),
		.fetchRestart(fetchRestart),
		.fetchEnable(fetchEnable),
		.startAddr(startAddr),
		.progWord(progWord),
		.progAddr(progAddr),
		.count(count),
		.push(push),
		.pushWord(pushWord)
	);

	instructionBuffer i_buffer (
		.txCLK(txCLK),
		.rst(rst),
		.flush(fetchRestart),
		.push(push),
		.pushWord(pushWord),
		.pop(pop),
		.headWord(headWord),
		.headValid(headValid),
		.count(count)
	);

	programSequencer i_sequencer (
		.txCLK(txCLK),
		.rst(rst),
		.txCommand(txCommand),
		.extTrigger(extTrigger),
		.ledReg(ledReg),
		.trigReg(trigReg),
		.trigRestReg(trigRestReg),
		.headWord(headWord),
		.headValid(headValid),
		.pop(pop),
		.fetchRestart(fetchRestart),
		.fetchEnable(fetchEnable),
		.trigOut(trigOut),
		.ledOut(ledOut),
		.adcTrigger(adcTrigger),
		.adcTriggerAck(adcTriggerAck),
		.fireStrobe(fireStrobe),
		.clearPulse(clearPulse)
	);

	pulseGenerator i_pulse (
		.txCLK(txCLK),
		.rst(rst),
		.fireStrobe(fireStrobe),
		.clearPulse(clearPulse),
		.pulseTiming(pulseTiming),
		.channelMask(channelMask),
		.transducerOut(transducerOut),
		.pulseBusy(pulseBusy)
	);

endmodule

/* dv/txControl_assertions.sv */
module txControl_assertions (
	input  logic txCLK,
	input  logic rst,
	input  txPkg::txCommand_t txCommand,
	input  txPkg::chanBits_t transducerOut,
	input  txPkg::chanBits_t ledOut,
	input  logic adcTrigger,
	input  logic adcTriggerAck
);

	int failCount = 0;

	// the ADC line only drops on an acknowledge
	adcHeld: assert property (@(posedge txCLK) disable iff (rst)
		$fell(adcTrigger) |-> $past(adcTriggerAck))
	else
	begin
		failCount++;
		$error("adcTrigger fell without adcTriggerAck in the previous cycle");
	end

	pulseQuiet: assert property (@(posedge txCLK) disable iff (rst)
		(txCommand != txPkg::cmdRunProgram) |=> (transducerOut == '0))
	else
	begin
		failCount++;
		$error("transducerOut not zero one cycle after a non-run command");
	end

	ledCleared: assert property (@(posedge txCLK) disable iff (rst)
		(txCommand inside {txPkg::cmdHardReset, txPkg::cmdSoftReset}) |=> (ledOut == '0))
	else
	begin
		failCount++;
		$error("ledOut not zero one cycle after a reset command");
	end

endmodule

bind txControlTop txControl_assertions i_assertions (
	.txCLK(txCLK),
	.rst(rst),
	.txCommand(txCommand),
	.transducerOut(transducerOut),
	.ledOut(ledOut),
	.adcTrigger(adcTrigger),
	.adcTriggerAck(adcTriggerAck)
);

/* dv/txControlTb.sv */
module txControlTb;

	logic txCLK;
	logic rst;
	txPkg::txCommand_t txCommand;
	logic extTrigger;
	txPkg::progAddr_t startAddr;
	txPkg::instrWord_t progWord;
	txPkg::progAddr_t progAddr;
	txPkg::channelTimingArray_t pulseTiming;
	txPkg::chanBits_t channelMask;
	txPkg::chanBits_t transducerOut;
	txPkg::chanBits_t trigOut;
	txPkg::chanBits_t ledOut;
	logic adcTrigger;
	logic adcTriggerAck;
	txPkg::chanBits_t ledReg;
	txPkg::chanBits_t trigReg;
	txPkg::chanBits_t trigRestReg;

	txPkg::instrWord_t progMem [64];
	integer seed = 12756;

	txControlTop i_dut (.*);

	initial
	begin
		txCLK = 1'b0;
		forever #50 txCLK = ~txCLK;
	end

	// program memory returns the word one cycle after the address
	always @(posedge txCLK)
		progWord <= #1 progMem[progAddr[5:0]];

	task automatic nextCycle();
		@(posedge txCLK);
		#1;
	endtask

	task automatic reportFailure(input string text);
		$display("%s", text);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic checkValue(input string testName, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
			reportFailure($sformatf("[ERROR] %s: expected %0h, actual %0h",
				testName, expected, actual));
	endtask

	function automatic txPkg::instrType_t typeBit(input int pos);
		txPkg::instrType_t flags;
		flags = '0;
		flags[pos] = 1'b1;
		return flags;
	endfunction

	task automatic putWord(input int addr, input txPkg::instrType_t flags,
		input txPkg::instrData_t data, input txPkg::delay_t delay);
		progMem[addr] = {flags, data, delay};
	endtask

	// two load cycles give the restart and the first read, then run
	task automatic runProgram(input txPkg::progAddr_t base);
		startAddr = base;
		txCommand = txPkg::cmdLoadProgram;
		nextCycle();
		checkValue("program address", base, progAddr);
		nextCycle();
		txCommand = txPkg::cmdRunProgram;
	endtask

	task automatic manualControls();
		ledReg = 8'($random(seed)) | 8'h01;
		trigReg = 8'($random(seed)) | 8'h01;
		trigRestReg = 8'($random(seed)) | 8'h01;
		txCommand = txPkg::cmdSetLed;
		nextCycle();
		checkValue("manual setLed", ledReg, ledOut);
		txCommand = txPkg::cmdSetTrig;
		nextCycle();
		checkValue("manual setTrig", trigReg, trigOut);
		txCommand = txPkg::cmdSetTrigRest;
		nextCycle();
		txCommand = txPkg::cmdTestTrig;
		nextCycle();
		checkValue("manual testTrig", trigReg ^ trigRestReg, trigOut);
		// LEDs lit again so the soft reset has something to clear
		txCommand = txPkg::cmdSetLed;
		nextCycle();
		txCommand = txPkg::cmdSoftReset;
		nextCycle();
		checkValue("manual softReset trig", trigRestReg, trigOut);
		checkValue("manual softReset led", 0, ledOut);
		txCommand = txPkg::cmdHardReset;
		nextCycle();
		checkValue("manual hardReset trig", 0, trigOut);
	endtask

	task automatic programOrder();
		txPkg::chanBits_t rest;
		txPkg::chanBits_t curTrig;
		txPkg::chanBits_t curLed;
		txPkg::chanBits_t newTrig;
		txPkg::chanBits_t trigField;
		txPkg::chanBits_t ledField;
		txPkg::instrType_t flags;
		logic [15:0] expected [6];
		logic [15:0] prev;
		int kind;
		int idx;
		int cycles;
		rest = 8'($random(seed));
		trigRestReg = rest;
		txCommand = txPkg::cmdSetTrigRest;
		nextCycle();
		curTrig = rest;
		curLed = '0;
		// every instruction changes at least one output so each one is seen
		for (int i = 0; i < 6; i++)
		begin
			kind = $unsigned($random(seed)) % 3;
			flags = '0;
			trigField = 8'($random(seed));
			ledField = 8'($random(seed));
			if (kind != 1)
			begin
				do
				begin
					newTrig = 8'($random(seed));
				end
				while (newTrig == curTrig);
				curTrig = newTrig;
				trigField = newTrig ^ rest;
				flags[txPkg::bitSetTrig] = 1'b1;
			end
			if (kind != 0)
			begin
				do
				begin
					ledField = 8'($random(seed));
				end
				while (ledField == curLed);
				curLed = ledField;
				flags[txPkg::bitSetLeds] = 1'b1;
			end
			expected[i] = {curTrig, curLed};
			putWord(8 + i, flags, {ledField, trigField}, 32'($unsigned($random(seed)) % 4));
		end
		putWord(14, typeBit(txPkg::bitProgramEnd), '0, 0);
		// a word past the end that must never run
		putWord(15, typeBit(txPkg::bitSetLeds), {~curLed, 8'h00}, 0);
		runProgram(8);
		prev = {trigOut, ledOut};
		idx = 0;
		cycles = 0;
		while (idx < 6)
		begin
			nextCycle();
			cycles++;
			if (cycles > 200)
				reportFailure("program order: outputs stopped changing before the program end");
			if ({trigOut, ledOut} != prev)
			begin
				checkValue("program order", expected[idx], {trigOut, ledOut});
				prev = {trigOut, ledOut};
				idx++;
			end
		end
		for (int i = 0; i < 20; i++)
		begin
			nextCycle();
			checkValue("program hold", prev, {trigOut, ledOut});
		end
	endtask

	task automatic delayCheck();
		txPkg::delay_t delay;
		txPkg::chanBits_t first;
		txPkg::chanBits_t second;
		int cycles;
		delay = 32'd200 + 32'($unsigned($random(seed)) % 200);
		first = 8'($random(seed)) | 8'h01;
		second = ~first;
		putWord(16, typeBit(txPkg::bitSetLeds), {first, 8'h00}, 0);
		putWord(17, typeBit(txPkg::bitSetLeds), {second, 8'h00}, delay);
		putWord(18, typeBit(txPkg::bitProgramEnd), '0, 0);
		runProgram(16);
		cycles = 0;
		while (ledOut !== first)
		begin
			nextCycle();
			cycles++;
			if (cycles > 50)
				reportFailure("delay: first LED instruction never executed");
		end
		cycles = 0;
		while (ledOut !== second)
		begin
			nextCycle();
			cycles++;
			if (cycles > delay + 10)
				reportFailure("delay: delayed LED instruction never executed");
		end
		if (cycles <= delay)
			reportFailure($sformatf("delay: LED changed after %0d cycles, delay is %0d",
				cycles, delay));
	endtask

	task automatic extTriggerWait();
		txPkg::chanBits_t ledVal;
		int cycles;
		ledVal = 8'($random(seed)) | 8'h01;
		putWord(24, typeBit(txPkg::bitWaitExtTrig), '0, 0);
		putWord(25, typeBit(txPkg::bitSetLeds), {ledVal, 8'h00}, 0);
		putWord(26, typeBit(txPkg::bitProgramEnd), '0, 0);
		runProgram(24);
		for (int i = 0; i < 60; i++)
		begin
			nextCycle();
			checkValue("ext trigger hold", 0, ledOut);
		end
		extTrigger = 1'b1;
		nextCycle();
		extTrigger = 1'b0;
		cycles = 0;
		while (ledOut !== ledVal)
		begin
			nextCycle();
			cycles++;
			if (cycles > 20)
				reportFailure("ext trigger: LED instruction did not run after the trigger");
		end
	endtask

	task automatic adcTriggerCheck();
		int cycles;
		putWord(32, typeBit(txPkg::bitTriggerRecv), '0, 0);
		putWord(33, typeBit(txPkg::bitProgramEnd), '0, 0);
		runProgram(32);
		cycles = 0;
		while (adcTrigger !== 1'b1)
		begin
			nextCycle();
			cycles++;
			if (cycles > 20)
				reportFailure("adc trigger: adcTrigger never rose");
		end
		for (int i = 0; i < 30; i++)
		begin
			nextCycle();
			checkValue("adc trigger hold", 1, adcTrigger);
		end
		adcTriggerAck = 1'b1;
		nextCycle();
		adcTriggerAck = 1'b0;
		cycles = 0;
		while (adcTrigger !== 1'b0)
		begin
			nextCycle();
			cycles++;
			if (cycles > 5)
				reportFailure("adc trigger: adcTrigger stayed high after the acknowledge");
		end
	endtask

	task automatic firePulse();
		txPkg::channelTimingArray_t timing;
		txPkg::chanBits_t mask;
		int highCount [txPkg::numChannels];
		int cycles;
		for (int c = 0; c < txPkg::numChannels; c++)
		begin
			timing[c].startTime = 16'($unsigned($random(seed)) % 32);
			timing[c].onTime = 16'($unsigned($random(seed)) % 31) + 16'd2;
			highCount[c] = 0;
		end
		mask = 8'($random(seed)) | 8'h01;
		pulseTiming = timing;
		channelMask = mask;
		putWord(40, typeBit(txPkg::bitFirePulse), '0, 0);
		putWord(41, typeBit(txPkg::bitProgramEnd), '0, 0);
		runProgram(40);
		cycles = 0;
		while (!i_dut.i_pulse.pulseBusy)
		begin
			nextCycle();
			cycles++;
			if (cycles > 20)
				reportFailure("fire pulse: pulse generator never started");
		end
		cycles = 0;
		while (i_dut.i_pulse.pulseBusy)
		begin
			nextCycle();
			cycles++;
			if (cycles > 200)
				reportFailure("fire pulse: pulse generator stayed busy");
			for (int c = 0; c < txPkg::numChannels; c++)
				if (transducerOut[c])
					highCount[c]++;
		end
		for (int c = 0; c < txPkg::numChannels; c++)
			checkValue($sformatf("fire channel %0d", c),
				mask[c] ? timing[c].onTime : 16'd0, highCount[c]);
		for (int i = 0; i < 5; i++)
		begin
			nextCycle();
			checkValue("fire idle", 0, transducerOut);
		end
		// a non-run command cuts a running pulse short
		runProgram(40);
		cycles = 0;
		while (transducerOut == '0)
		begin
			nextCycle();
			cycles++;
			if (cycles > 60)
				reportFailure("fire abort: no transducer channel went high");
		end
		txCommand = txPkg::cmdSoftReset;
		nextCycle();
		checkValue("fire abort", 0, transducerOut);
	endtask

	initial
	begin
		rst = 1'b1;
		txCommand = txPkg::cmdHardReset;
		extTrigger = 1'b0;
		startAddr = '0;
		progWord = '0;
		pulseTiming = '0;
		channelMask = '0;
		adcTriggerAck = 1'b0;
		ledReg = '0;
		trigReg = '0;
		trigRestReg = '0;
		// unused words are end words tagged with their own address
		for (int a = 0; a < 64; a++)
			progMem[a] = {typeBit(txPkg::bitProgramEnd), 16'(a), 32'(a)};
		repeat (4) @(posedge txCLK);
		#1;
		rst = 1'b0;
		manualControls();
		programOrder();
		delayCheck();
		extTriggerWait();
		adcTriggerCheck();
		firePulse();
		if (i_dut.i_assertions.failCount == 0)
		begin
			$display("TEST RESULT: PASS");
			$finish;
		end
		else
			reportFailure($sformatf("%0d assertion failures", i_dut.i_assertions.failCount));
	end

endmodule

/* flist.f */
common/txPkg.sv
hdl/instructionFetcher.sv
hdl/instructionBuffer.sv
sequencer/programSequencer.sv
sequencer/pulseGenerator.sv
hdl/txControlTop.sv
dv/txControl_assertions.sv
dv/txControlTb.sv

/* run.sh */
#!/bin/sh
# build and run the txControl testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module txControlTb -o simv

out=$(./obj_dir/simv +verilator+error+limit+100 2>&1) || true
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
	exit 0
fi
exit 1
